/* filelist.f */
source/ooo_pkg.sv
source/reg_file.sv
source/reorder_buffer.sv
source/operand_select.sv
source/rename_core.sv
test/tb_rename_core.sv

/* run_sim.sh */
#!/bin/sh
# build and run the rename core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_rename_core \
    -f filelist.f \
    -o sim_tb_rename_core

./obj_dir/sim_tb_rename_core

/* source/ooo_pkg.sv */
package ooo_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int xlen      = 32;
    localparam int num_regs  = 32;
    localparam int rob_depth = 7;   // tags 1..7, tag 0 means no dependency

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // basic vectors
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [xlen-1:0]                  data_t;
    typedef logic [$clog2(num_regs)-1:0]      reg_idx_t;
    typedef logic [$clog2(rob_depth+1)-1:0]   tag_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // issue and result bundles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
    } issue_req_t;

    // value only meaningful when tag is zero
    typedef struct packed {
        data_t value;
        tag_t  tag;
    } operand_t;

    typedef struct packed {
        operand_t op1;
        operand_t op2;
        tag_t     dest_tag;
    } issue_resp_t;

    typedef struct packed {
        tag_t  tag;
        data_t data;
    } wb_t;

    typedef struct packed {
        reg_idx_t rd;
        tag_t     tag;
        data_t    data;
    } commit_t;

    // reorder buffer entry life cycle
    typedef enum logic [1:0] {
        rob_free,
        rob_waiting,
        rob_done
    } rob_state_e;

endpackage

/* source/operand_select.sv */
`timescale 1ns/1ps

module operand_select (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue_fire,
    input  ooo_pkg::data_t       rs1_val,
    input  ooo_pkg::data_t       rs2_val,
    input  ooo_pkg::tag_t        rs1_tag,
    input  ooo_pkg::tag_t        rs2_tag,
    input  logic                 query_done1,
    input  logic                 query_done2,
    input  ooo_pkg::data_t       query_data1,
    input  ooo_pkg::data_t       query_data2,
    input  logic                 wb_valid,
    input  ooo_pkg::wb_t         wb,
    input  ooo_pkg::tag_t        dest_tag,
    output logic                 resp_valid,
    output ooo_pkg::issue_resp_t resp
);

    ooo_pkg::operand_t op1;
    ooo_pkg::operand_t op2;

    // register value, then bypass, then finished entry, else the tag
    function automatic ooo_pkg::operand_t resolve(
        input ooo_pkg::data_t val,
        input ooo_pkg::tag_t  tag,
        input logic           done,
        input ooo_pkg::data_t qdata,
        input logic           wbv,
        input ooo_pkg::wb_t   w
    );
        ooo_pkg::operand_t op;
        op.value = '0;
        op.tag   = '0;
        if (tag == '0) begin
            op.value = val;
        end else if (wbv && w.tag == tag) begin
            op.value = w.data;   // same-cycle result
        end else if (done) begin
            op.value = qdata;
        end else begin
            op.tag = tag;
        end
        return op;
    endfunction

    always_comb begin
        op1 = resolve(rs1_val, rs1_tag, query_done1, query_data1, wb_valid, wb);
        op2 = resolve(rs2_val, rs2_tag, query_done2, query_data2, wb_valid, wb);
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= issue_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            resp.op1      <= op1;
            resp.op2      <= op2;
            resp.dest_tag <= dest_tag;
        end
    end

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic              clk,
    input  logic              rst,
    input  logic              rename_en,
    input  ooo_pkg::reg_idx_t rename_rd,
    input  ooo_pkg::tag_t     rename_tag,
    input  ooo_pkg::reg_idx_t rs1,
    input  ooo_pkg::reg_idx_t rs2,
    input  logic              commit_valid,
    input  ooo_pkg::commit_t  commit,
    output ooo_pkg::data_t    rs1_val,
    output ooo_pkg::data_t    rs2_val,
    output ooo_pkg::tag_t     rs1_tag,
    output ooo_pkg::tag_t     rs2_tag
);

    ooo_pkg::data_t regs [ooo_pkg::num_regs];
    ooo_pkg::tag_t  tags [ooo_pkg::num_regs];   // producer of each register

    ooo_pkg::operand_t src1;
    ooo_pkg::operand_t src2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // source reads
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the pending commit is visible in its own cycle, so a freed
    // buffer slot never leaves a stale tag behind
    function automatic ooo_pkg::operand_t read_src(
        input ooo_pkg::reg_idx_t idx,
        input ooo_pkg::data_t    val,
        input ooo_pkg::tag_t     tag,
        input logic              cv,
        input ooo_pkg::commit_t  cm
    );
        ooo_pkg::operand_t op;
        op.value = val;
        op.tag   = tag;
        if (idx == '0) begin
            op.value = '0;     // x0 hardwired
            op.tag   = '0;
        end else if (cv && cm.rd == idx && tag == cm.tag) begin
            op.value = cm.data;
            op.tag   = '0;
        end
        return op;
    endfunction

    always_comb begin
        src1 = read_src(rs1, regs[rs1], tags[rs1], commit_valid, commit);
        src2 = read_src(rs2, regs[rs2], tags[rs2], commit_valid, commit);
    end

    assign rs1_val = src1.value;
    assign rs1_tag = src1.tag;
    assign rs2_val = src2.value;
    assign rs2_tag = src2.tag;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // commit and rename
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < ooo_pkg::num_regs; i++) begin
                regs[i] <= '0;
                tags[i] <= '0;
            end
        end else begin
            if (commit_valid && commit.rd != '0) begin
                regs[commit.rd] <= commit.data;
                // only the latest producer releases the register
                if (tags[commit.rd] == commit.tag) begin
                    tags[commit.rd] <= '0;
                end
            end
            if (rename_en && rename_rd != '0) begin
                tags[rename_rd] <= rename_tag;   // rename wins over commit
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // tag 0 would make the new producer look already resolved
    rename_tag_nonzero: assert property (
        @(posedge clk) disable iff (!rst)
        rename_en |-> rename_tag != '0
    ) else $error("reg_file: rename with tag zero");

endmodule

/* source/rename_core.sv */
`timescale 1ns/1ps

module rename_core (
    input  logic                 clk,
    input  logic                 rst,
    // issue
    input  logic                 issue_valid,
    input  ooo_pkg::issue_req_t  issue_req,
    output logic                 issue_ready,
    output logic                 issue_resp_valid,
    output ooo_pkg::issue_resp_t issue_resp,
    // writeback from the execution units
    input  logic                 wb_valid,
    input  ooo_pkg::wb_t         wb,
    // retirement
    output logic                 commit_valid,
    output ooo_pkg::commit_t     commit
);

    logic           issue_fire;
    ooo_pkg::tag_t  alloc_tag;

    ooo_pkg::data_t rs1_val;
    ooo_pkg::data_t rs2_val;
    ooo_pkg::tag_t  rs1_tag;
    ooo_pkg::tag_t  rs2_tag;

    logic           query_done1;
    logic           query_done2;
    ooo_pkg::data_t query_data1;
    ooo_pkg::data_t query_data2;

    assign issue_fire = issue_valid && issue_ready;

    reg_file i_reg_file (
        .clk          (clk),
        .rst          (rst),
        .rename_en    (issue_fire),
        .rename_rd    (issue_req.rd),
        .rename_tag   (alloc_tag),
        .rs1          (issue_req.rs1),
        .rs2          (issue_req.rs2),
        .commit_valid (commit_valid),
        .commit       (commit),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .rs1_tag      (rs1_tag),
        .rs2_tag      (rs2_tag)
    );

    reorder_buffer i_reorder_buffer (
        .clk          (clk),
        .rst          (rst),
        .alloc_en     (issue_fire),
        .alloc_rd     (issue_req.rd),
        .wb_valid     (wb_valid),
        .wb           (wb),
        .query_tag1   (rs1_tag),      // source tags looked up directly
        .query_tag2   (rs2_tag),
        .alloc_ready  (issue_ready),
        .alloc_tag    (alloc_tag),
        .query_done1  (query_done1),
        .query_done2  (query_done2),
        .query_data1  (query_data1),
        .query_data2  (query_data2),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    operand_select i_operand_select (
        .clk         (clk),
        .rst         (rst),
        .issue_fire  (issue_fire),
        .rs1_val     (rs1_val),
        .rs2_val     (rs2_val),
        .rs1_tag     (rs1_tag),
        .rs2_tag     (rs2_tag),
        .query_done1 (query_done1),
        .query_done2 (query_done2),
        .query_data1 (query_data1),
        .query_data2 (query_data2),
        .wb_valid    (wb_valid),
        .wb          (wb),
        .dest_tag    (alloc_tag),
        .resp_valid  (issue_resp_valid),
        .resp        (issue_resp)
    );

endmodule

/* source/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer (
    input  logic              clk,
    input  logic              rst,
    input  logic              alloc_en,
    input  ooo_pkg::reg_idx_t alloc_rd,
    input  logic              wb_valid,
    input  ooo_pkg::wb_t      wb,
    input  ooo_pkg::tag_t     query_tag1,
    input  ooo_pkg::tag_t     query_tag2,
    output logic              alloc_ready,
    output ooo_pkg::tag_t     alloc_tag,
    output logic              query_done1,
    output logic              query_done2,
    output ooo_pkg::data_t    query_data1,
    output ooo_pkg::data_t    query_data2,
    output logic              commit_valid,
    output ooo_pkg::commit_t  commit
);

    ooo_pkg::rob_state_e state    [ooo_pkg::rob_depth];
    ooo_pkg::reg_idx_t   ent_rd   [ooo_pkg::rob_depth];
    ooo_pkg::data_t      ent_data [ooo_pkg::rob_depth];

    // pointers are entry indexes, tag = index + 1
    ooo_pkg::tag_t head;
    ooo_pkg::tag_t tail;
    ooo_pkg::tag_t count;          // entries in use, 0..7

    ooo_pkg::tag_t wb_idx;
    ooo_pkg::tag_t q1_idx;
    ooo_pkg::tag_t q2_idx;

    logic do_alloc;
    logic do_retire;

    function automatic ooo_pkg::tag_t next_ptr(input ooo_pkg::tag_t p);
        if (p == ooo_pkg::tag_t'(ooo_pkg::rob_depth - 1)) begin
            return '0;
        end
        return p + ooo_pkg::tag_t'(1);
    endfunction

    assign alloc_ready = (count != ooo_pkg::tag_t'(ooo_pkg::rob_depth));
    assign alloc_tag   = tail + ooo_pkg::tag_t'(1);
    assign do_alloc    = alloc_en && alloc_ready;
    assign do_retire   = (state[head] == ooo_pkg::rob_done);   // oldest first

    assign wb_idx = wb.tag - ooo_pkg::tag_t'(1);
    assign q1_idx = query_tag1 - ooo_pkg::tag_t'(1);
    assign q2_idx = query_tag2 - ooo_pkg::tag_t'(1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // source lookups
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign query_done1 = (query_tag1 != '0) && (state[q1_idx] == ooo_pkg::rob_done);
    assign query_done2 = (query_tag2 != '0) && (state[q2_idx] == ooo_pkg::rob_done);
    assign query_data1 = (query_tag1 != '0) ? ent_data[q1_idx] : '0;
    assign query_data2 = (query_tag2 != '0) ? ent_data[q2_idx] : '0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // entry state and pointers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            commit_valid <= 1'b0;
            for (int i = 0; i < ooo_pkg::rob_depth; i++) begin
                state[i] <= ooo_pkg::rob_free;
            end
        end else begin
            commit_valid <= do_retire;
            if (do_alloc) begin
                state[tail] <= ooo_pkg::rob_waiting;
                tail        <= next_ptr(tail);
            end
            if (wb_valid && wb.tag != '0) begin
                state[wb_idx] <= ooo_pkg::rob_done;
            end
            if (do_retire) begin
                state[head] <= ooo_pkg::rob_free;
                head        <= next_ptr(head);
            end
            // slot freed by retire is usable only next cycle
            case ({do_alloc, do_retire})
                2'b10:   count <= count + ooo_pkg::tag_t'(1);
                2'b01:   count <= count - ooo_pkg::tag_t'(1);
                default: count <= count;
            endcase
        end
    end

    // payload, no reset needed
    always_ff @(posedge clk) begin
        if (do_alloc) begin
            ent_rd[tail] <= alloc_rd;
        end
        if (wb_valid && wb.tag != '0) begin
            ent_data[wb_idx] <= wb.data;
        end
        if (do_retire) begin
            commit.rd   <= ent_rd[head];
            commit.tag  <= head + ooo_pkg::tag_t'(1);
            commit.data <= ent_data[head];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    wb_tag_waiting: assert property (
        @(posedge clk) disable iff (!rst)
        wb_valid |-> (wb.tag != '0) && (state[wb_idx] == ooo_pkg::rob_waiting)
    ) else $error("reorder_buffer: writeback to tag %0d not waiting", wb.tag);

    // the issue strobe from the top must respect back-pressure
    no_alloc_full: assert property (
        @(posedge clk) disable iff (!rst)
        alloc_en |-> alloc_ready
    ) else $error("reorder_buffer: allocation while full");

endmodule

/* test/tb_rename_core.sv */
`timescale 1ns/1ps

module tb_rename_core;

    logic                 clk;
    logic                 rst;
    logic                 issue_valid;
    ooo_pkg::issue_req_t  issue_req;
    logic                 issue_ready;
    logic                 issue_resp_valid;
    ooo_pkg::issue_resp_t issue_resp;
    logic                 wb_valid;
    ooo_pkg::wb_t         wb;
    logic                 commit_valid;
    ooo_pkg::commit_t     commit;

    // instruction records in issue order
    ooo_pkg::tag_t     rec_tag  [$];
    ooo_pkg::reg_idx_t rec_rd   [$];
    ooo_pkg::data_t    rec_data [$];
    logic              rec_done [$];   // result written back

    int                   prod [ooo_pkg::num_regs];   // latest producer record, -1 none
    int                   wb_pending [$];
    int                   commit_order [$];
    ooo_pkg::issue_resp_t resp_expected [$];

    ooo_pkg::tag_t next_tag;
    int            in_use;
    int            stall_cycles;
    int            hold_wb;        // cycles left with the execution units idle
    int            commits_seen;

    rename_core i_dut (
        .clk              (clk),
        .rst              (rst),
        .issue_valid      (issue_valid),
        .issue_req        (issue_req),
        .issue_ready      (issue_ready),
        .issue_resp_valid (issue_resp_valid),
        .issue_resp       (issue_resp),
        .wb_valid         (wb_valid),
        .wb               (wb),
        .commit_valid     (commit_valid),
        .commit           (commit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [72:0] got,
                                   input logic [72:0] exp);
        $display("FAIL t=%0t %s got=%h expected=%h", $time, name, got, exp);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic ooo_pkg::operand_t predict_operand(input ooo_pkg::reg_idx_t rs);
        ooo_pkg::operand_t op;
        int                p;
        op = '0;
        p  = prod[rs];
        if (rs != 5'd0 && p >= 0) begin
            if (rec_done[p]) begin
                op.value = rec_data[p];   // written back, maybe committed
            end else begin
                op.tag = rec_tag[p];
            end
        end
        return op;
    endfunction

    function automatic ooo_pkg::issue_resp_t predict_response(
        input ooo_pkg::issue_req_t req,
        input ooo_pkg::tag_t       dest
    );
        ooo_pkg::issue_resp_t r;
        r.op1      = predict_operand(req.rs1);
        r.op2      = predict_operand(req.rs2);
        r.dest_tag = dest;
        return r;
    endfunction

    function automatic ooo_pkg::commit_t predict_commit(input int n);
        ooo_pkg::commit_t c;
        c.rd   = rec_rd[n];
        c.tag  = rec_tag[n];
        c.data = rec_data[n];
        return c;
    endfunction

    function automatic ooo_pkg::reg_idx_t random_reg();
        return ooo_pkg::reg_idx_t'($urandom % 8);   // small pool, many hazards
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // driver, one call per cycle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic step(input logic valid, input ooo_pkg::issue_req_t req,
                        output logic accepted);
        int k;
        int n;
        if (commit_valid) begin
            in_use--;   // head left at the last edge
        end
        assert (issue_ready === (in_use != 7)) else
            report_mismatch("issue_ready", 73'(issue_ready), 73'(in_use != 7));
        wb_valid = 1'b0;
        if (hold_wb > 0) begin
            hold_wb--;
        end else if (wb_pending.size() > 0 && ($urandom % 4) != 0) begin
            k = int'($urandom % wb_pending.size());
            n = wb_pending[k];
            wb_pending.delete(k);
            rec_done[n] = 1'b1;
            wb_valid    = 1'b1;
            wb.tag      = rec_tag[n];
            wb.data     = rec_data[n];
        end
        issue_valid = valid;
        issue_req   = req;
        accepted    = valid && issue_ready;
        if (valid && !issue_ready) begin
            stall_cycles++;
        end
        if (accepted) begin
            resp_expected.push_back(predict_response(req, next_tag));
            n = rec_tag.size();
            rec_tag.push_back(next_tag);
            rec_rd.push_back(req.rd);
            rec_data.push_back($urandom);
            rec_done.push_back(1'b0);
            wb_pending.push_back(n);
            commit_order.push_back(n);
            if (req.rd != 5'd0) begin
                prod[req.rd] = n;   // sources above saw the older mapping
            end
            next_tag = (next_tag == 3'd7) ? 3'd1 : next_tag + 3'd1;
            in_use++;
        end
        @(posedge clk);
        #10;
    endtask

    task automatic issue_one(input ooo_pkg::reg_idx_t rs1, input ooo_pkg::reg_idx_t rs2,
                             input ooo_pkg::reg_idx_t rd);
        ooo_pkg::issue_req_t req;
        logic                acc;
        int                  waited;
        req.rs1 = rs1;
        req.rs2 = rs2;
        req.rd  = rd;
        acc     = 1'b0;
        waited  = 0;
        while (!acc && waited < 60) begin
            step(1'b1, req, acc);
            waited++;
        end
        if (!acc) begin
            fail_run("timeout: issue request was never accepted");
        end
    endtask

    task automatic drain();
        logic acc;
        int   waited;
        waited = 0;
        while ((commit_order.size() > 0 || resp_expected.size() > 0) && waited < 200) begin
            step(1'b0, '0, acc);
            waited++;
        end
        if (commit_order.size() > 0 || resp_expected.size() > 0) begin
            fail_run("timeout: reorder buffer did not drain");
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare process
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        ooo_pkg::issue_resp_t exp_resp;
        ooo_pkg::commit_t     exp_commit;
        logic                 fired;
        int                   n;
        fired = 1'b0;
        forever begin
            @(negedge clk);
            if (rst) begin
                assert (issue_resp_valid === fired) else
                    report_mismatch("issue_resp_valid", 73'(issue_resp_valid), 73'(fired));
                if (issue_resp_valid) begin
                    exp_resp = resp_expected.pop_front();
                    assert (issue_resp === exp_resp) else
                        report_mismatch("issue_resp", issue_resp, exp_resp);
                end
                if (commit_valid) begin
                    assert (commit_order.size() > 0) else
                        fail_run("commit pulse with nothing in flight");
                    n = commit_order.pop_front();
                    assert (rec_done[n]) else
                        fail_run("commit before the result was written back");
                    exp_commit = predict_commit(n);
                    assert (commit === exp_commit) else
                        report_mismatch("commit", 73'(commit), 73'(exp_commit));
                    commits_seen++;
                end
            end
            fired = issue_valid && issue_ready;   // response due next cycle
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        logic acc;
        void'($urandom(32'h23ee_a053));
        rst          = 1'b0;
        issue_valid  = 1'b0;
        issue_req    = '0;
        wb_valid     = 1'b0;
        wb           = '0;
        next_tag     = 3'd1;
        in_use       = 0;
        stall_cycles = 0;
        hold_wb      = 0;
        commits_seen = 0;
        for (int i = 0; i < ooo_pkg::num_regs; i++) begin
            prod[i] = -1;
        end
        repeat (3) @(posedge clk);
        #10;
        rst = 1'b1;
        assert (issue_ready === 1'b1) else
            report_mismatch("issue_ready", 73'(issue_ready), 73'(1'b1));
        assert (commit_valid === 1'b0) else
            report_mismatch("commit_valid", 73'(commit_valid), 73'(1'b0));

        // every register reads zero, results go to x0
        for (int i = 0; i < 16; i++) begin
            issue_one(ooo_pkg::reg_idx_t'(2 * i), ooo_pkg::reg_idx_t'(2 * i + 1), 5'd0);
        end

        // rs equal to rd and a register renamed twice
        issue_one(5'd5, 5'd5, 5'd5);
        issue_one(5'd5, 5'd5, 5'd5);
        issue_one(5'd5, 5'd0, 5'd6);
        issue_one(5'd6, 5'd5, 5'd5);

        for (int i = 0; i < 240; i++) begin
            if (($urandom % 5) == 0) begin
                step(1'b0, '0, acc);
            end else begin
                issue_one(random_reg(), random_reg(), random_reg());
            end
        end

        // fill the buffer with the execution units held back
        drain();
        hold_wb      = 12;
        stall_cycles = 0;
        for (int i = 0; i < 10; i++) begin
            issue_one(random_reg(), random_reg(), random_reg());
        end
        assert (stall_cycles > 0) else
            fail_run("issue_ready never dropped with a full reorder buffer");

        issue_one(5'd0, 5'd0, 5'd0);
        issue_one(5'd0, 5'd3, 5'd0);
        issue_one(5'd3, 5'd0, 5'd0);
        drain();

        if (commits_seen == rec_tag.size() && in_use == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("SOME TESTS FAILED");
            $fatal(1, "instructions lost or duplicated");
        end
    end

endmodule
